// File: isaPkg.sv
// Instruction set definitions
package isaPkg;

   typedef logic [15:0] wordT;     // Data word, also a byte address
   typedef logic [2:0]  regAddrT;  // Index into the eight general registers

   localparam int numRegs = 8;

   // Field positions inside the 16-bit instruction word
   localparam int opMsb = 15;
   localparam int opLsb = 11;
   localparam int rsMsb = 10;  // Rs is the first source and the branch operand
   localparam int rsLsb = 8;
   localparam int rtMsb = 7;
   localparam int rtLsb = 5;

   localparam regAddrT linkReg = 3'd7;  // JAL and JALR leave the return address here

   // Opcode field, bits 15:11
   typedef enum logic [4:0] {
      halt    = 5'b00000,
      nop     = 5'b00001,
      jDisp   = 5'b00100,  // PC-relative jump with an 11-bit displacement
      jr      = 5'b00101,
      jal     = 5'b00110,
      jalr    = 5'b00111,
      addi    = 5'b01000,
      subi    = 5'b01001,
      xori    = 5'b01010,
      andni   = 5'b01011,
      beqz    = 5'b01100,
      bnez    = 5'b01101,
      bltz    = 5'b01110,
      bgez    = 5'b01111,
      st      = 5'b10000,
      ld      = 5'b10001,
      slbi    = 5'b10010,
      stu     = 5'b10011,
      roli    = 5'b10100,
      slli    = 5'b10101,
      rori    = 5'b10110,
      srli    = 5'b10111,
      lbi     = 5'b11000,
      btr     = 5'b11001,
      shiftRr = 5'b11010,  // Register-register rotates and shifts
      aluRr   = 5'b11011,  // Register-register arithmetic and logic
      seq     = 5'b11100,
      slt     = 5'b11101,
      sle     = 5'b11110,
      sco     = 5'b11111
   } opcodeT;

   // Width of the immediate field carried by an instruction
   typedef enum logic [1:0] {
      none,  // No immediate, the stage passes zero
      i1,    // Bits 4:0
      i2,    // Bits 7:0
      jd     // Bits 10:0
   } immFormatT;

endpackage

// File: pipePkg.sv
// Pipeline stage packets
package pipePkg;

   // Instruction as handed over by fetch
   typedef struct packed {
      isaPkg::wordT pc;     // Address of this instruction, not of the next one
      isaPkg::wordT instr;
   } fetchPktT;

   // Register write coming back from a later stage
   typedef struct packed {
      logic            en;    // Honored in the cycle it is presented
      isaPkg::regAddrT addr;
      isaPkg::wordT    data;
   } wbReqT;

   // Control-flow decision made in decode
   typedef struct packed {
      logic         taken;   // Fetch has to restart at target
      isaPkg::wordT target;
   } redirectT;

   // Everything that the execute stage needs from decode
   typedef struct packed {
      isaPkg::wordT pc;
      isaPkg::wordT instr;
      isaPkg::wordT rsData;  // Register operands as read in the acceptance cycle
      isaPkg::wordT rtData;
      isaPkg::wordT imm;     // Already extended for the instruction format
      redirectT     redir;
   } decodePktT;

endpackage

// File: regFile.sv
// Register file with write bypass
`timescale 1ns/1ps

module regFile (
   input  logic            clk,
   input  logic            rst,
   input  isaPkg::regAddrT rdAddrA,
   input  isaPkg::regAddrT rdAddrB,
   output isaPkg::wordT    rdDataA,
   output isaPkg::wordT    rdDataB,
   input  logic            wrEn,
   input  isaPkg::regAddrT wrAddr,
   input  isaPkg::wordT    wrData
);

   isaPkg::wordT regs [isaPkg::numRegs];  // All eight are general purpose, r0 included

   logic hitA;
   logic hitB;

   // Registers read as zero after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < isaPkg::numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;  // Lands at the edge, so the array lags by one cycle
      end
   end

   // A write in flight to the same register is forwarded to the reader
   assign hitA = wrEn && (wrAddr == rdAddrA);
   assign hitB = wrEn && (wrAddr == rdAddrB);

   assign rdDataA = hitA ? wrData : regs[rdAddrA];
   assign rdDataB = hitB ? wrData : regs[rdAddrB];

   // Both writers of the port must present a known index when they write
   wrAddrKnown: assert property (
      @(posedge clk) disable iff (rst)
      wrEn |-> !$isunknown(wrAddr)
   ) else $error("regFile: write enabled with an unknown address");

endmodule

// File: immExtend.sv
// Immediate selection and extension
`timescale 1ns/1ps

module immExtend (
   input  isaPkg::wordT instr,
   output isaPkg::wordT imm
);

   isaPkg::opcodeT    op;
   isaPkg::immFormatT fmt;
   logic              zeroExt;  // Upper bits are filled with zeros instead of the sign

   assign op = isaPkg::opcodeT'(instr[isaPkg::opMsb:isaPkg::opLsb]);

   // Format follows the opcode alone
   always_comb begin
      fmt     = isaPkg::none;
      zeroExt = 1'b0;
      case (op)
         isaPkg::addi, isaPkg::subi, isaPkg::st, isaPkg::ld, isaPkg::stu: begin
            fmt = isaPkg::i1;  // Arithmetic and address offsets are signed
         end
         isaPkg::xori, isaPkg::andni, isaPkg::roli, isaPkg::slli, isaPkg::rori,
         isaPkg::srli: begin
            fmt     = isaPkg::i1;
            zeroExt = 1'b1;  // Logical masks and shift counts are unsigned
         end
         isaPkg::beqz, isaPkg::bnez, isaPkg::bltz, isaPkg::bgez, isaPkg::lbi,
         isaPkg::jr, isaPkg::jalr: begin
            fmt = isaPkg::i2;
         end
         isaPkg::slbi: begin
            fmt     = isaPkg::i2;
            zeroExt = 1'b1;  // Shifted into the low byte, so no sign
         end
         isaPkg::jDisp, isaPkg::jal: begin
            fmt = isaPkg::jd;  // Displacement is always signed
         end
         default: begin
            fmt = isaPkg::none;  // Register formats, halt and nop
         end
      endcase
   end

   always_comb begin
      case (fmt)
         isaPkg::i1: imm = {{11{instr[4] & ~zeroExt}}, instr[4:0]};
         isaPkg::i2: imm = {{8{instr[7] & ~zeroExt}}, instr[7:0]};
         isaPkg::jd: imm = {{5{instr[10]}}, instr[10:0]};
         default:    imm = '0;
      endcase
   end

endmodule

// File: branchResolve.sv
// Branch and jump resolution
`timescale 1ns/1ps

module branchResolve (
   input  isaPkg::wordT      pc,
   input  isaPkg::wordT      instr,
   input  isaPkg::wordT      rsData,
   input  isaPkg::wordT      imm,
   output pipePkg::redirectT redir
);

   isaPkg::opcodeT op;
   isaPkg::wordT   pcPlus2;    // Sequential successor
   isaPkg::wordT   relTarget;  // PC-relative destination of branches, J and JAL
   isaPkg::wordT   regTarget;  // Register-based destination of JR and JALR
   logic           rsZero;
   logic           rsNeg;

   assign op        = isaPkg::opcodeT'(instr[isaPkg::opMsb:isaPkg::opLsb]);
   assign pcPlus2   = pc + 16'd2;
   assign relTarget = pcPlus2 + imm;
   assign regTarget = rsData + imm;

   // Condition flags come from Rs only
   assign rsZero = (rsData == '0);
   assign rsNeg  = rsData[15];

   always_comb begin
      redir.taken  = 1'b0;
      redir.target = pcPlus2;  // Falls through unless a case below says otherwise
      case (op)
         // Branch target is formed whatever the condition, taken decides the use
         isaPkg::beqz: begin
            redir.taken  = rsZero;
            redir.target = relTarget;
         end
         isaPkg::bnez: begin
            redir.taken  = ~rsZero;
            redir.target = relTarget;
         end
         isaPkg::bltz: begin
            redir.taken  = rsNeg;
            redir.target = relTarget;
         end
         isaPkg::bgez: begin
            redir.taken  = ~rsNeg;
            redir.target = relTarget;
         end
         isaPkg::jDisp, isaPkg::jal: begin
            redir.taken  = 1'b1;
            redir.target = relTarget;
         end
         isaPkg::jr, isaPkg::jalr: begin
            redir.taken  = 1'b1;
            redir.target = regTarget;
         end
         default: begin
            redir.taken  = 1'b0;  // Halt stops fetch elsewhere, it never redirects
            redir.target = pcPlus2;
         end
      endcase
   end

   // Fetch relies on halt leaving the sequential path alone
   haltNeverTaken: assert final (!(op == isaPkg::halt && redir.taken))
      else $error("branchResolve: halt produced a taken redirect");

endmodule

// File: decodeStage.sv
// Decode stage top level
`timescale 1ns/1ps

module decodeStage (
   input  logic               clk,
   input  logic               rst,
   input  pipePkg::fetchPktT  in,
   input  logic               inValid,
   output logic               inReady,
   input  pipePkg::wbReqT     wb,
   output pipePkg::decodePktT out,
   output logic               outValid,
   input  logic               outReady
);

   isaPkg::opcodeT     op;
   isaPkg::regAddrT    rsAddr;
   isaPkg::regAddrT    rtAddr;
   isaPkg::wordT       rsData;
   isaPkg::wordT       rtData;
   isaPkg::wordT       imm;
   isaPkg::wordT       pcPlus2;  // Return address of JAL and JALR
   pipePkg::redirectT  redir;
   pipePkg::decodePktT nextPkt;

   logic            isLinkOp;      // Instruction at the input writes r7
   logic            linkConflict;  // Link write would collide with a writeback
   logic            outFree;       // Output register can take a packet this cycle
   logic            accept;
   logic            linkWrite;
   logic            wrEn;
   isaPkg::regAddrT wrAddr;
   isaPkg::wordT    wrData;

   assign op      = isaPkg::opcodeT'(in.instr[isaPkg::opMsb:isaPkg::opLsb]);
   assign rsAddr  = in.instr[isaPkg::rsMsb:isaPkg::rsLsb];
   assign rtAddr  = in.instr[isaPkg::rtMsb:isaPkg::rtLsb];
   assign pcPlus2 = in.pc + 16'd2;

   assign isLinkOp = (op == isaPkg::jal) || (op == isaPkg::jalr);

   // Writeback cannot wait, so a JAL or JALR stalls a cycle when both want the port
   assign linkConflict = inValid && isLinkOp && wb.en;
   assign outFree      = !outValid || outReady;
   assign inReady      = outFree && !linkConflict;
   assign accept       = inValid && inReady;
   assign linkWrite    = accept && isLinkOp;

   // Single write port, wb has priority and the conflict stall keeps linkWrite away
   assign wrEn   = wb.en || linkWrite;
   assign wrAddr = wb.en ? wb.addr : isaPkg::linkReg;
   assign wrData = wb.en ? wb.data : pcPlus2;

   // The link write is bypassed like any other, so a JALR through r7 reads pc+2
   regFile u_regFile (
      .clk     (clk),
      .rst     (rst),
      .rdAddrA (rsAddr),
      .rdAddrB (rtAddr),
      .rdDataA (rsData),
      .rdDataB (rtData),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData)
   );

   immExtend u_immExtend (
      .instr (in.instr),
      .imm   (imm)
   );

   branchResolve u_branchResolve (
      .pc     (in.pc),
      .instr  (in.instr),
      .rsData (rsData),
      .imm    (imm),
      .redir  (redir)
   );

   always_comb begin
      nextPkt.pc     = in.pc;
      nextPkt.instr  = in.instr;
      nextPkt.rsData = rsData;
      nextPkt.rtData = rtData;
      nextPkt.imm    = imm;
      nextPkt.redir  = redir;
   end

   // Valid drops once the held packet leaves and nothing new came in
   always_ff @(posedge clk) begin
      if (rst) begin
         outValid <= 1'b0;
      end else if (outFree) begin
         outValid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out <= nextPkt;  // Only loads on acceptance, so a stalled packet holds
      end
   end

   outHeldWhileStalled: assert property (
      @(posedge clk) disable iff (rst)
      outValid && !outReady |=> outValid && $stable(out)
   ) else $error("decodeStage: output changed while stalled");

   outIdleAfterReset: assert property (
      @(posedge clk)
      rst |=> !outValid
   ) else $error("decodeStage: outValid high right after reset");

   // Writeback keeps the port and the link instruction waits at the input
   linkYieldsToWb: assert property (
      @(posedge clk) disable iff (rst)
      inValid && isLinkOp && wb.en |-> !inReady
   ) else $error("decodeStage: link write accepted under a writeback");

endmodule

// File: decodeStageTb.sv
// Decode stage testbench
`timescale 1ns/1ps

module decodeStageTb;

   logic               clk = 1'b0;
   logic               rst = 1'b1;  // Held for the first five rising edges
   pipePkg::fetchPktT  in = '0;
   logic               inValid = 1'b0;
   logic               inReady;
   pipePkg::wbReqT     wb = '0;
   pipePkg::decodePktT out;
   logic               outValid;
   logic               outReady = 1'b0;

   // Stimulus table, one slot per test in every queue
   string              names[$];
   pipePkg::fetchPktT  pkts[$];
   pipePkg::wbReqT     wbs[$];
   isaPkg::wordT       imms[$];
   pipePkg::redirectT  redirs[$];
   pipePkg::decodePktT expQ[$];  // Completed expectations in acceptance order

   isaPkg::wordT model [isaPkg::numRegs];  // Register contents as the ISA rules predict
   logic [31:0]  lfsr = 32'h0fac_f6c9;
   int           errors = 0;
   int           passed = 0;
   int           failed = 0;
   int           cycles = 0;
   int           limit = 0;

   decodeStage u_decodeStage (.clk(clk), .rst(rst), .in(in), .inValid(inValid),
      .inReady(inReady), .wb(wb), .out(out), .outValid(outValid), .outReady(outReady));

   always #2 clk = ~clk;

   // Fibonacci form with taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Opcode, Rs and the low byte, which also holds Rt in bits 7:5
   function automatic isaPkg::wordT enc(input isaPkg::opcodeT op, input isaPkg::regAddrT rs,
                                        input logic [7:0] low);
      return {op, rs, low};
   endfunction

   function automatic pipePkg::wbReqT wr(input isaPkg::regAddrT a, input isaPkg::wordT d);
      return {1'b1, a, d};
   endfunction

   task automatic addTest(input string name, input isaPkg::wordT pc, input isaPkg::wordT instr,
                          input pipePkg::wbReqT w, input isaPkg::wordT imm,
                          input pipePkg::redirectT redir);
      names.push_back(name);
      pkts.push_back({pc, instr});
      wbs.push_back(w);
      imms.push_back(imm);
      redirs.push_back(redir);
   endtask

   task automatic checkWord(input string name, input string field, input isaPkg::wordT exp,
                            input isaPkg::wordT act, inout int bad);
      if (act !== exp) begin
         $display("FAIL %s %s: expected %h, actual %h", name, field, exp, act);
         bad++;
      end
   endtask

   task automatic checkRedir(input string name, input pipePkg::redirectT exp,
                             input pipePkg::redirectT act, inout int bad);
      if (act !== exp) begin
         $display("FAIL %s redir: expected taken %b target %h, actual taken %b target %h",
                  name, exp.taken, exp.target, act.taken, act.target);
         bad++;
      end
   endtask

   task automatic checkOut(input string name, input pipePkg::decodePktT exp);
      int bad = 0;
      checkWord(name, "pc", exp.pc, out.pc, bad);
      checkWord(name, "instr", exp.instr, out.instr, bad);
      checkWord(name, "rsData", exp.rsData, out.rsData, bad);
      checkWord(name, "rtData", exp.rtData, out.rtData, bad);
      checkWord(name, "imm", exp.imm, out.imm, bad);
      checkRedir(name, exp.redir, out.redir, bad);
      errors += bad;
      if (bad == 0) begin
         passed++;
         $display("ok   %s", name);
      end else begin
         failed++;
      end
   endtask

   // Called when a test first reaches the input, so its wb lands before the read
   task automatic expectFor(input int i);
      pipePkg::decodePktT e;
      isaPkg::opcodeT     op;
      op = isaPkg::opcodeT'(pkts[i].instr[15:11]);
      if (wbs[i].en) model[wbs[i].addr] = wbs[i].data;
      if (op == isaPkg::jal || op == isaPkg::jalr) begin
         model[isaPkg::linkReg] = pkts[i].pc + 16'd2;  // Written in the acceptance cycle too
      end
      e.pc     = pkts[i].pc;
      e.instr  = pkts[i].instr;
      e.rsData = model[pkts[i].instr[10:8]];
      e.rtData = model[pkts[i].instr[7:5]];
      e.imm    = imms[i];
      e.redir  = redirs[i];
      expQ.push_back(e);
   endtask

   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout after %0d cycles, the decode stage stopped moving packets", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      int                 sent;   // Tests accepted at the input
      int                 done;   // Tests seen leaving on out
      logic               fresh;  // Current test has not been presented yet
      logic               acc;
      logic               held;
      pipePkg::decodePktT heldPkt;
      for (int r = 0; r < isaPkg::numRegs; r++) model[r] = '0;
      addTest("reset r0 r1", 16'h100, enc(isaPkg::nop, 3'd0, 8'h20), '0, 16'h0, {1'b0, 16'h102});
      addTest("reset r2 r3", 16'h102, enc(isaPkg::nop, 3'd2, 8'h60), '0, 16'h0, {1'b0, 16'h104});
      addTest("reset r4 r5", 16'h104, enc(isaPkg::nop, 3'd4, 8'hA0), '0, 16'h0, {1'b0, 16'h106});
      addTest("reset r6 r7", 16'h106, enc(isaPkg::nop, 3'd6, 8'hE0), '0, 16'h0, {1'b0, 16'h108});
      addTest("bypass rs", 16'h108, enc(isaPkg::nop, 3'd1, 8'h40), wr(3'd1, 16'h0005),
              16'h0, {1'b0, 16'h10A});
      addTest("bypass rt", 16'h10A, enc(isaPkg::nop, 3'd1, 8'h40), wr(3'd2, 16'h8003),
              16'h0, {1'b0, 16'h10C});
      // Rs is r0 for zero, r1 for positive and r2 for negative
      addTest("beqz zero", 16'h300, enc(isaPkg::beqz, 3'd0, 8'h10), '0, 16'h10, {1'b1, 16'h312});
      addTest("beqz pos", 16'h300, enc(isaPkg::beqz, 3'd1, 8'h10), '0, 16'h10, {1'b0, 16'h312});
      addTest("beqz neg", 16'h300, enc(isaPkg::beqz, 3'd2, 8'hF0), '1, 16'hFFF0, {1'b0, 16'h2F2});
      addTest("bnez zero", 16'h300, enc(isaPkg::bnez, 3'd0, 8'h10), '0, 16'h10, {1'b0, 16'h312});
      addTest("bnez pos", 16'h300, enc(isaPkg::bnez, 3'd1, 8'h10), '0, 16'h10, {1'b1, 16'h312});
      addTest("bnez neg", 16'h300, enc(isaPkg::bnez, 3'd2, 8'hF0), '0, 16'hFFF0, {1'b1, 16'h2F2});
      addTest("bltz zero", 16'h300, enc(isaPkg::bltz, 3'd0, 8'h10), '0, 16'h10, {1'b0, 16'h312});
      addTest("bltz pos", 16'h300, enc(isaPkg::bltz, 3'd1, 8'h10), '0, 16'h10, {1'b0, 16'h312});
      addTest("bltz neg", 16'h300, enc(isaPkg::bltz, 3'd2, 8'hF0), '0, 16'hFFF0, {1'b1, 16'h2F2});
      addTest("bgez zero", 16'h300, enc(isaPkg::bgez, 3'd0, 8'h10), '0, 16'h10, {1'b1, 16'h312});
      addTest("bgez pos", 16'h300, enc(isaPkg::bgez, 3'd1, 8'h10), '0, 16'h10, {1'b1, 16'h312});
      addTest("bgez neg", 16'h300, enc(isaPkg::bgez, 3'd2, 8'hF0), '0, 16'hFFF0, {1'b0, 16'h2F2});
      addTest("j back", 16'h400, enc(isaPkg::jDisp, 3'd7, 8'hFE), '0, 16'hFFFE, {1'b1, 16'h400});
      addTest("jal", 16'h600, enc(isaPkg::jal, 3'd0, 8'h10), '0, 16'h10, {1'b1, 16'h612});
      addTest("jr r7", 16'h700, enc(isaPkg::jr, 3'd7, 8'h04), '0, 16'h4, {1'b1, 16'h606});
      addTest("jal wb clash", 16'h800, enc(isaPkg::jal, 3'd0, 8'h02), wr(3'd4, 16'h1234),
              16'h2, {1'b1, 16'h804});
      addTest("read r7 r4", 16'h804, enc(isaPkg::nop, 3'd7, 8'h80), '0, 16'h0, {1'b0, 16'h806});
      addTest("jalr wb r7", 16'h900, enc(isaPkg::jalr, 3'd2, 8'h02), wr(3'd7, 16'hAAAA),
              16'h2, {1'b1, 16'h8005});
      addTest("addi i1 r7", 16'hA00, enc(isaPkg::addi, 3'd7, 8'h1F), '0, 16'hFFFF, {1'b0, 16'hA02});
      addTest("xori zext", 16'hA00, enc(isaPkg::xori, 3'd1, 8'h1F), '0, 16'h1F, {1'b0, 16'hA02});
      addTest("lbi i2", 16'hA00, enc(isaPkg::lbi, 3'd3, 8'h80), '0, 16'hFF80, {1'b0, 16'hA02});
      addTest("andni zext", 16'hA00, enc(isaPkg::andni, 3'd1, 8'h90), '0, 16'h10, {1'b0, 16'hA02});
      addTest("halt", 16'hA00, enc(isaPkg::halt, 3'd0, 8'h00), '0, 16'h0, {1'b0, 16'hA02});
      addTest("alu rr", 16'hA00, enc(isaPkg::aluRr, 3'd1, 8'h40), '0, 16'h0, {1'b0, 16'hA02});
      limit = names.size() * 8 + 50;
      sent  = 0;
      done  = 0;
      fresh = 1'b1;
      held  = 1'b0;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;
      if (outValid !== 1'b0 || inReady !== 1'b1) begin
         $display("Handshake is wrong after reset, outValid %b inReady %b", outValid, inReady);
         errors++;
      end
      while (done < names.size()) begin
         lfsr     = lfsrStep(lfsr);
         outReady = lfsr[0];
         if (sent < names.size()) begin
            if (fresh) begin
               expectFor(sent);
               if (wbs[sent].en) outReady = 1'b1;  // The read meets its own wb on the bypass
            end
            wb      = fresh ? wbs[sent] : '0;  // A wb is presented for one cycle only
            in      = pkts[sent];
            inValid = 1'b1;
            fresh   = 1'b0;
         end else begin
            inValid = 1'b0;
            wb      = '0;
         end
         @(negedge clk);  // Handshake and outputs are settled here
         if (held && (outValid !== 1'b1 || out !== heldPkt)) begin
            $display("Output packet changed while it was held by back-pressure");
            errors++;
         end
         held    = outValid && !outReady;
         heldPkt = out;
         acc     = inValid && inReady;
         if (outValid && outReady) begin
            if (done < sent) checkOut(names[done], expQ[done]);
            else begin
               $display("Output transferred a packet that was never accepted");
               errors++;
            end
            done++;
         end
         @(posedge clk);
         #1;
         if (acc) begin
            sent++;
            fresh = 1'b1;
         end
      end
      if (outValid !== 1'b0) begin
         $display("Output still valid after the last packet left the stage");
         errors++;
      end
      if (sent != names.size()) begin
         $display("Accepted %0d packets but %0d left the stage", sent, done);
         errors++;
      end
      $display("Tests %0d, passed %0d, failed %0d, errors %0d", names.size(), passed, failed,
               errors);
      if (errors == 0) $display("SIMULATION PASSED");
      else $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: flist.f
isaPkg.sv
pipePkg.sv
regFile.sv
immExtend.sv
branchResolve.sv
decodeStage.sv
decodeStageTb.sv
